/* chess_eval_pkg.sv */
package chess_eval_pkg;

   parameter int score_width = 24;

   // bit 3 set marks a black piece
   typedef enum logic [3:0]
   {
      empty_square = 4'h0,
      white_pawn   = 4'h1,
      white_knight = 4'h2,
      white_bishop = 4'h3,
      white_rook   = 4'h4,
      white_queen  = 4'h5,
      white_king   = 4'h6,
      black_pawn   = 4'h9,
      black_knight = 4'hA,
      black_bishop = 4'hB,
      black_rook   = 4'hC,
      black_queen  = 4'hD,
      black_king   = 4'hE
   } piece_t;

   typedef piece_t [63:0] board_t;  // square 0 in the low nibble

   typedef struct packed
   {
      logic [15:0] pawn;
      logic [15:0] knight;
      logic [15:0] bishop;
      logic [15:0] rook;
      logic [15:0] queen;
      logic [15:0] king;
   } piece_values_t;

   typedef struct packed
   {
      logic signed [7:0] eg;
      logic signed [7:0] mg;
   } centre_bonus_t;

   typedef struct packed
   {
      logic signed [score_width-1:0] score_mg;
      logic signed [score_width-1:0] score_eg;
      logic signed [31:0]            material;
      logic                          insufficient;
   } eval_result_t;

   typedef enum logic [1:0]
   {
      st_idle   = 2'd0,
      st_settle = 2'd1,
      st_hold   = 2'd2
   } seq_state_t;

   typedef enum logic [7:0]
   {
      addr_pawn     = 8'h00,
      addr_knight   = 8'h04,
      addr_bishop   = 8'h08,
      addr_rook     = 8'h0C,
      addr_queen    = 8'h10,
      addr_king     = 8'h14,
      addr_bonus    = 8'h18,
      addr_score_mg = 8'h20,  // read only from here on
      addr_score_eg = 8'h24,
      addr_material = 8'h28,
      addr_status   = 8'h2C
   } reg_addr_t;

   function automatic logic piece_is_black(piece_t p);
      return p[3];
   endfunction

   // white adds, black subtracts
   function automatic logic signed [16:0] piece_value(piece_t p, piece_values_t v);
      logic [15:0] mag;
      case (p)
         white_pawn, black_pawn:     mag = v.pawn;
         white_knight, black_knight: mag = v.knight;
         white_bishop, black_bishop: mag = v.bishop;
         white_rook, black_rook:     mag = v.rook;
         white_queen, black_queen:   mag = v.queen;
         white_king, black_king:     mag = v.king;
         default:                    mag = '0;
      endcase
      if (piece_is_black(p))
         return -$signed({1'b0, mag});
      return $signed({1'b0, mag});
   endfunction

endpackage

/* eval_config_regs.sv */
module eval_config_regs
(
   input  logic                          clk,
   input  logic                          reset,

   input  logic [7:0]                    paddr,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [31:0]                   pwdata,
   output logic [31:0]                   prdata,
   output logic                          pready,
   output logic                          pslverr,

   input  chess_eval_pkg::eval_result_t  result,
   input  logic                          eval_valid,
   output chess_eval_pkg::piece_values_t values,
   output chess_eval_pkg::centre_bonus_t bonus
);

   logic                         access;
   logic                         addr_ok;
   logic                         addr_ro;
   chess_eval_pkg::eval_result_t last_result;

   assign access = psel & penable;
   assign pready = 1'b1;  // no wait states
   assign pslverr = access & (~addr_ok | (pwrite & addr_ro));

   //////////////////////////////
   // address decode
   //////////////////////////////

   always_comb
   begin
      addr_ok = 1'b1;
      addr_ro = 1'b0;
      case (paddr)
         chess_eval_pkg::addr_pawn,
         chess_eval_pkg::addr_knight,
         chess_eval_pkg::addr_bishop,
         chess_eval_pkg::addr_rook,
         chess_eval_pkg::addr_queen,
         chess_eval_pkg::addr_king,
         chess_eval_pkg::addr_bonus:    addr_ro = 1'b0;
         chess_eval_pkg::addr_score_mg,
         chess_eval_pkg::addr_score_eg,
         chess_eval_pkg::addr_material,
         chess_eval_pkg::addr_status:   addr_ro = 1'b1;
         default:                       addr_ok = 1'b0;
      endcase
   end

   always_comb
   begin
      case (paddr)
         chess_eval_pkg::addr_pawn:     prdata = {16'd0, values.pawn};
         chess_eval_pkg::addr_knight:   prdata = {16'd0, values.knight};
         chess_eval_pkg::addr_bishop:   prdata = {16'd0, values.bishop};
         chess_eval_pkg::addr_rook:     prdata = {16'd0, values.rook};
         chess_eval_pkg::addr_queen:    prdata = {16'd0, values.queen};
         chess_eval_pkg::addr_king:     prdata = {16'd0, values.king};
         chess_eval_pkg::addr_bonus:    prdata = {16'd0, bonus.eg, bonus.mg};
         chess_eval_pkg::addr_score_mg: prdata = 32'(last_result.score_mg);  // sign extended
         chess_eval_pkg::addr_score_eg: prdata = 32'(last_result.score_eg);
         chess_eval_pkg::addr_material: prdata = last_result.material;
         chess_eval_pkg::addr_status:   prdata = {30'd0, eval_valid, last_result.insufficient};
         default:                       prdata = '0;
      endcase
   end

   //////////////////////////////
   // register writes and capture
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         values      <= '0;
         bonus       <= '0;
         last_result <= '0;
      end
      else
      begin
         if (eval_valid)
            last_result <= result;
         if (access && pwrite && addr_ok && !addr_ro)
         begin
            case (paddr)
               chess_eval_pkg::addr_pawn:   values.pawn   <= pwdata[15:0];
               chess_eval_pkg::addr_knight: values.knight <= pwdata[15:0];
               chess_eval_pkg::addr_bishop: values.bishop <= pwdata[15:0];
               chess_eval_pkg::addr_rook:   values.rook   <= pwdata[15:0];
               chess_eval_pkg::addr_queen:  values.queen  <= pwdata[15:0];
               chess_eval_pkg::addr_king:   values.king   <= pwdata[15:0];
               chess_eval_pkg::addr_bonus:
               begin
                  bonus.mg <= pwdata[7:0];
                  bonus.eg <= pwdata[15:8];
               end
               default: ;
            endcase
         end
      end
   end

endmodule

/* material_balance.sv */
module material_balance
(
   input  logic                          clk,
   input  chess_eval_pkg::board_t        board,
   input  chess_eval_pkg::piece_values_t values,
   output logic signed [31:0]            material,
   output logic                          insufficient
);

   logic signed [18:0] group_t1 [16];  // four squares each
   logic signed [20:0] block_t2 [4];   // sixteen squares each
   logic [1:0]         white_wt_t1 [64];
   logic [1:0]         black_wt_t1 [64];
   logic [7:0]         white_cnt;
   logic [7:0]         black_cnt;
   logic [7:0]         white_sum_t2;
   logic [7:0]         black_sum_t2;

   // minor pieces weigh 1, anything that can still mate alone weighs 3
   function automatic logic [1:0] piece_weight(chess_eval_pkg::piece_t p);
      case (p)
         chess_eval_pkg::white_pawn, chess_eval_pkg::black_pawn,
         chess_eval_pkg::white_rook, chess_eval_pkg::black_rook,
         chess_eval_pkg::white_queen, chess_eval_pkg::black_queen:   return 2'd3;
         chess_eval_pkg::white_knight, chess_eval_pkg::black_knight,
         chess_eval_pkg::white_bishop, chess_eval_pkg::black_bishop: return 2'd1;
         default:                                                    return 2'd0;
      endcase
   endfunction

   always_comb
   begin
      white_cnt = '0;
      black_cnt = '0;
      for (int s = 0; s < 64; s++)
      begin
         white_cnt = white_cnt + 8'(white_wt_t1[s]);
         black_cnt = black_cnt + 8'(black_wt_t1[s]);
      end
   end

   always_ff @(posedge clk)
   begin
      // stage 1
      for (int g = 0; g < 16; g++)
         group_t1[g] <= chess_eval_pkg::piece_value(board[4*g], values) +
                        chess_eval_pkg::piece_value(board[4*g+1], values) +
                        chess_eval_pkg::piece_value(board[4*g+2], values) +
                        chess_eval_pkg::piece_value(board[4*g+3], values);
      for (int s = 0; s < 64; s++)
      begin
         white_wt_t1[s] <= chess_eval_pkg::piece_is_black(board[s]) ? 2'd0 : piece_weight(board[s]);
         black_wt_t1[s] <= chess_eval_pkg::piece_is_black(board[s]) ? piece_weight(board[s]) : 2'd0;
      end

      // stage 2
      for (int b = 0; b < 4; b++)
         block_t2[b] <= group_t1[4*b] + group_t1[4*b+1] + group_t1[4*b+2] + group_t1[4*b+3];
      white_sum_t2 <= white_cnt;
      black_sum_t2 <= black_cnt;

      // stage 3
      material <= 32'(block_t2[0]) + 32'(block_t2[1]) + 32'(block_t2[2]) + 32'(block_t2[3]);
      insufficient <= (white_sum_t2 == 8'd0 && black_sum_t2 <= 8'd1) ||
                      (black_sum_t2 == 8'd0 && white_sum_t2 <= 8'd1);
   end

endmodule

/* square_score_tree.sv */
module square_score_tree
#(
   parameter int EVAL_WIDTH = 24
)
(
   input  logic                          clk,
   input  chess_eval_pkg::board_t        board,
   input  chess_eval_pkg::piece_values_t values,
   input  chess_eval_pkg::centre_bonus_t bonus,
   input  logic                          insufficient,
   output logic signed [EVAL_WIDTH-1:0]  score_mg,
   output logic signed [EVAL_WIDTH-1:0]  score_eg
);

   logic signed [17:0]           sq_mg_t1 [64];
   logic signed [17:0]           sq_eg_t1 [64];
   logic signed [EVAL_WIDTH-1:0] half_mg_t2 [16];  // index is 2*rank + half
   logic signed [EVAL_WIDTH-1:0] half_eg_t2 [16];
   logic signed [EVAL_WIDTH-1:0] pair_mg_t3 [4];   // ranks 2p and 2p+1
   logic signed [EVAL_WIDTH-1:0] pair_eg_t3 [4];

   // ranks 2..5, files 2..5
   function automatic logic is_centre(int s);
      return (s / 8) >= 2 && (s / 8) <= 5 && (s % 8) >= 2 && (s % 8) <= 5;
   endfunction

   function automatic logic signed [8:0] centre_term
   (
      int                     s,
      chess_eval_pkg::piece_t p,
      logic signed [7:0]      b
   );
      if (!is_centre(s) || p == chess_eval_pkg::empty_square)
         return 9'sd0;
      if (chess_eval_pkg::piece_is_black(p))
         return -9'(b);
      return 9'(b);
   endfunction

   //////////////////////////////
   // stage 1, per square
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      for (int s = 0; s < 64; s++)
      begin
         sq_mg_t1[s] <= chess_eval_pkg::piece_value(board[s], values) +
                        centre_term(s, board[s], bonus.mg);
         sq_eg_t1[s] <= chess_eval_pkg::piece_value(board[s], values) +
                        centre_term(s, board[s], bonus.eg);
      end
   end

   //////////////////////////////
   // stages 2 to 4, adder tree
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      for (int h = 0; h < 16; h++)
      begin
         half_mg_t2[h] <= sq_mg_t1[4*h] + sq_mg_t1[4*h+1] + sq_mg_t1[4*h+2] + sq_mg_t1[4*h+3];
         half_eg_t2[h] <= sq_eg_t1[4*h] + sq_eg_t1[4*h+1] + sq_eg_t1[4*h+2] + sq_eg_t1[4*h+3];
      end

      for (int p = 0; p < 4; p++)
      begin
         pair_mg_t3[p] <= half_mg_t2[4*p] + half_mg_t2[4*p+1] +
                          half_mg_t2[4*p+2] + half_mg_t2[4*p+3];
         pair_eg_t3[p] <= half_eg_t2[4*p] + half_eg_t2[4*p+1] +
                          half_eg_t2[4*p+2] + half_eg_t2[4*p+3];
      end

      if (insufficient)  // flag arrives from material_balance stage 3
      begin
         score_mg <= '0;
         score_eg <= '0;
      end
      else
      begin
         score_mg <= pair_mg_t3[0] + pair_mg_t3[1] + pair_mg_t3[2] + pair_mg_t3[3];
         score_eg <= pair_eg_t3[0] + pair_eg_t3[1] + pair_eg_t3[2] + pair_eg_t3[3];
      end
   end

endmodule

/* eval_sequencer.sv */
module eval_sequencer
(
   input  logic clk,
   input  logic reset,
   input  logic board_valid,
   input  logic clear_eval,
   output logic eval_valid
);

   localparam int settle_cycles = 5;

   chess_eval_pkg::seq_state_t state;
   logic                       board_valid_r;
   logic [2:0]                 settle_cnt;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= chess_eval_pkg::st_idle;
         board_valid_r <= 1'b0;
         settle_cnt    <= '0;
         eval_valid    <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;
         case (state)
            chess_eval_pkg::st_idle:
            begin
               settle_cnt <= '0;
               eval_valid <= 1'b0;
               if (board_valid && !board_valid_r)  // rising edge only
                  state <= chess_eval_pkg::st_settle;
            end
            chess_eval_pkg::st_settle:
            begin
               settle_cnt <= settle_cnt + 3'd1;
               if (settle_cnt == 3'(settle_cycles - 1))
                  state <= chess_eval_pkg::st_hold;
            end
            chess_eval_pkg::st_hold:
            begin
               if (clear_eval && eval_valid)
               begin
                  eval_valid <= 1'b0;
                  state      <= chess_eval_pkg::st_idle;
               end
               else
                  eval_valid <= 1'b1;
            end
            default: state <= chess_eval_pkg::st_idle;
         endcase
      end
   end

endmodule

/* chess_eval_top.sv */
module chess_eval_top
#(
   parameter int EVAL_WIDTH = 24
)
(
   input  logic                         clk,
   input  logic                         reset,

   input  logic [7:0]                   paddr,
   input  logic                         psel,
   input  logic                         penable,
   input  logic                         pwrite,
   input  logic [31:0]                  pwdata,
   output logic [31:0]                  prdata,
   output logic                         pready,
   output logic                         pslverr,

   input  chess_eval_pkg::board_t       board,
   input  logic                         board_valid,
   input  logic                         clear_eval,
   output chess_eval_pkg::eval_result_t result,
   output logic                         eval_valid
);

   localparam int score_w = chess_eval_pkg::score_width;

   chess_eval_pkg::piece_values_t values;
   chess_eval_pkg::centre_bonus_t bonus;
   logic signed [31:0]            material;
   logic                          insufficient;
   logic signed [EVAL_WIDTH-1:0]  score_mg;
   logic signed [EVAL_WIDTH-1:0]  score_eg;

   // scores resized to the result field width
   assign result.score_mg     = score_w'(score_mg);
   assign result.score_eg     = score_w'(score_eg);
   assign result.material     = material;
   assign result.insufficient = insufficient;

   eval_config_regs i_eval_config_regs
   (
      .clk        (clk),
      .reset      (reset),
      .paddr      (paddr),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .result     (result),
      .eval_valid (eval_valid),
      .values     (values),
      .bonus      (bonus)
   );

   material_balance i_material_balance
   (
      .clk          (clk),
      .board        (board),
      .values       (values),
      .material     (material),
      .insufficient (insufficient)
   );

   square_score_tree #(.EVAL_WIDTH(EVAL_WIDTH)) i_square_score_tree
   (
      .clk          (clk),
      .board        (board),
      .values       (values),
      .bonus        (bonus),
      .insufficient (insufficient),
      .score_mg     (score_mg),
      .score_eg     (score_eg)
   );

   eval_sequencer i_eval_sequencer
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .eval_valid  (eval_valid)
   );

endmodule

/* eval_clock_gen.sv */
module eval_clock_gen
#(
   parameter int period_ns    = 40,
   parameter int reset_cycles = 3
)
(
   output logic clk,
   output logic reset
);

   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #2 reset = 1'b0;  // released off the edge like other inputs
   end

endmodule

/* tb_chess_eval.sv */
module tb_chess_eval;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int sw              = chess_eval_pkg::score_width;
   localparam int num_tests       = 28;  // register test plus 27 boards
   localparam int watchdog_cycles = num_tests * 400 + 200;
   localparam int rise_limit      = 8;
   localparam int fall_limit      = 2;
   localparam int hold_cycles     = 10;

   logic                          clk;
   logic                          reset;
   logic [7:0]                    paddr;
   logic                          psel;
   logic                          penable;
   logic                          pwrite;
   logic [31:0]                   pwdata;
   logic [31:0]                   prdata;
   logic                          pready;
   logic                          pslverr;
   chess_eval_pkg::board_t        board;
   logic                          board_valid;
   logic                          clear_eval;
   chess_eval_pkg::eval_result_t  result;
   logic                          eval_valid;

   chess_eval_pkg::piece_values_t model_values;
   chess_eval_pkg::centre_bonus_t model_bonus;
   chess_eval_pkg::eval_result_t  expected;
   chess_eval_pkg::board_t        b;
   logic [31:0]                   exp_rdata;
   logic                          check_rdata;
   logic                          exp_slverr;
   int                            seed;

   eval_clock_gen #(.period_ns(40), .reset_cycles(3)) i_eval_clock_gen
   (
      .clk   (clk),
      .reset (reset)
   );

   chess_eval_top i_chess_eval_top
   (
      .clk         (clk),
      .reset       (reset),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .board       (board),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .result      (result),
      .eval_valid  (eval_valid)
   );

   task report_failure(input string msg);
      $display("FAILED at %0t ns: %s", $time, msg);
      $display("Verification failed");
      $fatal(1, "stopped at the first error");
   endtask

   //////////////////////////////
   // checks
   //////////////////////////////

   result_check: assert property (@(posedge clk) disable iff (reset)
      $rose(eval_valid) |-> (result == expected))
      else report_failure("result differs from the reference model");

   rdata_check: assert property (@(posedge clk) disable iff (reset)
      (psel && penable && !pwrite && check_rdata) |-> (prdata == exp_rdata))
      else report_failure($sformatf("read of 0x%02h returned wrong data", paddr));

   slverr_check: assert property (@(posedge clk) disable iff (reset)
      (psel && penable) |-> (pslverr == exp_slverr))
      else report_failure($sformatf("pslverr wrong for access to 0x%02h", paddr));

   pready_check: assert property (@(posedge clk) disable iff (reset)
      (psel && penable) |-> pready)
      else report_failure($sformatf("pready low for access to 0x%02h", paddr));

   //////////////////////////////
   // reference model
   //////////////////////////////

   function automatic chess_eval_pkg::eval_result_t reference_eval
   (
      input chess_eval_pkg::board_t        bd,
      input chess_eval_pkg::piece_values_t v,
      input chess_eval_pkg::centre_bonus_t c
   );
      chess_eval_pkg::eval_result_t r;
      int   kind_value [8];
      int   kind_weight [8] = '{0, 3, 1, 1, 3, 3, 0, 0};  // empty, pawn .. king
      logic [3:0] code;
      int   sign;
      int   val;
      int   bonus_mg;
      int   bonus_eg;
      int   mg;
      int   eg;
      int   mat;
      int   white_wt;
      int   black_wt;
      bit   centre;
      bit   short_material;
      kind_value = '{0, v.pawn, v.knight, v.bishop, v.rook, v.queen, v.king, 0};
      mg = 0;
      eg = 0;
      mat = 0;
      white_wt = 0;
      black_wt = 0;
      for (int s = 0; s < 64; s++)
      begin
         code = bd[s];
         sign = code[3] ? -1 : 1;
         val = kind_value[code[2:0]];
         centre = ((s / 8) inside {[2:5]}) && ((s % 8) inside {[2:5]});
         bonus_mg = (centre && code[2:0] != 3'd0) ? int'(c.mg) : 0;
         bonus_eg = (centre && code[2:0] != 3'd0) ? int'(c.eg) : 0;
         mat += sign * val;
         mg += sign * (val + bonus_mg);
         eg += sign * (val + bonus_eg);
         if (code[3])
            black_wt += kind_weight[code[2:0]];
         else
            white_wt += kind_weight[code[2:0]];
      end
      short_material = (white_wt == 0 && black_wt <= 1) || (black_wt == 0 && white_wt <= 1);
      r.material = mat;
      r.insufficient = short_material;
      r.score_mg = short_material ? '0 : sw'(mg);
      r.score_eg = short_material ? '0 : sw'(eg);
      return r;
   endfunction

   //////////////////////////////
   // stimulus helpers
   //////////////////////////////

   function automatic chess_eval_pkg::board_t empty_board();
      chess_eval_pkg::board_t e;
      for (int s = 0; s < 64; s++)
         e[s] = chess_eval_pkg::empty_square;
      return e;
   endfunction

   function automatic chess_eval_pkg::piece_t piece_from_index(input int idx);
      return chess_eval_pkg::piece_t'({idx >= 6, 3'(idx % 6 + 1)});  // 0..5 white, 6..11 black
   endfunction

   task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] data,
                             input logic err);
      paddr = addr;
      pwrite = wr;
      pwdata = wr ? data : 32'd0;
      exp_rdata = data;
      check_rdata = ~wr;
      exp_slverr = err;
      psel = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #2;
      penable = 1'b1;
      while (!pready)
      begin
         @(posedge clk);
         #2;
      end
      @(posedge clk);  // transfer completes here
      #2;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      check_rdata = 1'b0;
   endtask

   task automatic program_values(input chess_eval_pkg::piece_values_t v,
                                 input chess_eval_pkg::centre_bonus_t c);
      apb_access(chess_eval_pkg::addr_pawn, 1'b1, {16'd0, v.pawn}, 1'b0);
      apb_access(chess_eval_pkg::addr_knight, 1'b1, {16'd0, v.knight}, 1'b0);
      apb_access(chess_eval_pkg::addr_bishop, 1'b1, {16'd0, v.bishop}, 1'b0);
      apb_access(chess_eval_pkg::addr_rook, 1'b1, {16'd0, v.rook}, 1'b0);
      apb_access(chess_eval_pkg::addr_queen, 1'b1, {16'd0, v.queen}, 1'b0);
      apb_access(chess_eval_pkg::addr_king, 1'b1, {16'd0, v.king}, 1'b0);
      apb_access(chess_eval_pkg::addr_bonus, 1'b1, {16'd0, c.eg, c.mg}, 1'b0);
      model_values = v;
      model_bonus = c;
   endtask

   task automatic random_config();
      chess_eval_pkg::piece_values_t v;
      chess_eval_pkg::centre_bonus_t c;
      v.pawn = 16'($random(seed));
      v.knight = 16'($random(seed));
      v.bishop = 16'($random(seed));
      v.rook = 16'($random(seed));
      v.queen = 16'($random(seed));
      v.king = 16'($random(seed));
      c.mg = 8'($random(seed));
      c.eg = 8'($random(seed));
      program_values(v, c);
   endtask

   task automatic random_board(output chess_eval_pkg::board_t rb);
      int count;
      int sq;
      int idx;
      rb = empty_board();
      count = 1 + int'($unsigned($random(seed)) % 24);
      for (int n = 0; n < count; n++)
      begin
         sq = int'($unsigned($random(seed)) % 64);  // later drops may overwrite
         idx = int'($unsigned($random(seed)) % 12);
         rb[sq] = piece_from_index(idx);
      end
   endtask

   // load a board, wait for the result, read it back, then clear
   task automatic run_board(input chess_eval_pkg::board_t bd, input bit second_edge);
      int cycles;
      expected = reference_eval(bd, model_values, model_bonus);
      board = bd;
      board_valid = 1'b1;
      cycles = 0;
      do
      begin
         @(posedge clk);
         #2;
         board_valid = 1'b0;
         cycles++;
      end
      while (!eval_valid && cycles < rise_limit);
      assert (eval_valid) else report_failure("eval_valid did not rise within 8 cycles");
      for (int i = 0; i < hold_cycles; i++)
      begin
         @(posedge clk);
         #2;
         assert (eval_valid) else report_failure("eval_valid dropped without clear_eval");
      end
      apb_access(chess_eval_pkg::addr_score_mg, 1'b0, 32'(expected.score_mg), 1'b0);
      apb_access(chess_eval_pkg::addr_score_eg, 1'b0, 32'(expected.score_eg), 1'b0);
      apb_access(chess_eval_pkg::addr_material, 1'b0, expected.material, 1'b0);
      apb_access(chess_eval_pkg::addr_status, 1'b0, {30'd0, 1'b1, expected.insufficient}, 1'b0);
      if (second_edge)
      begin
         board_valid = 1'b1;  // ignored while held
         @(posedge clk);
         #2;
         board_valid = 1'b0;
      end
      clear_eval = 1'b1;
      cycles = 0;
      do
      begin
         @(posedge clk);
         #2;
         clear_eval = 1'b0;
         cycles++;
      end
      while (eval_valid && cycles < fall_limit);
      assert (!eval_valid) else report_failure("eval_valid did not fall within 2 cycles");
      if (second_edge)
      begin
         for (int i = 0; i < hold_cycles; i++)
         begin
            @(posedge clk);
            #2;
            assert (!eval_valid) else report_failure("board_valid during hold gave a new result");
         end
      end
   endtask

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial
   begin
      paddr = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      pwdata = '0;
      board = empty_board();
      board_valid = 1'b0;
      clear_eval = 1'b0;
      exp_rdata = '0;
      check_rdata = 1'b0;
      exp_slverr = 1'b0;
      expected = '0;
      model_values = '0;
      model_bonus = '0;
      seed = 22;

      do
         @(posedge clk);
      while (reset);
      #2;

      // registers after reset
      assert (!eval_valid) else report_failure("eval_valid is high after reset");
      for (int a = 0; a <= 'h2C; a += 4)
         apb_access(8'(a), 1'b0, 32'd0, a == 'h1C);  // 0x1C is unmapped
      apb_access(8'h20, 1'b1, 32'h1234, 1'b1);
      apb_access(8'h20, 1'b0, 32'd0, 1'b0);
      apb_access(8'h30, 1'b0, 32'd0, 1'b1);

      // kings only, then king and knight against king
      program_values('{100, 320, 330, 500, 900, 2000}, '{-8'sd10, 8'sd20});
      apb_access(chess_eval_pkg::addr_bonus, 1'b0, 32'h0000_F614, 1'b0);
      b = empty_board();
      b[4] = chess_eval_pkg::white_king;
      b[60] = chess_eval_pkg::black_king;
      run_board(b, 1'b0);
      b[18] = chess_eval_pkg::white_knight;
      run_board(b, 1'b0);

      // single pieces on and off the centre
      b = empty_board();
      b[27] = chess_eval_pkg::white_queen;
      b[63] = chess_eval_pkg::black_king;
      run_board(b, 1'b0);
      b = empty_board();
      b[36] = chess_eval_pkg::black_pawn;
      b[0] = chess_eval_pkg::white_rook;
      run_board(b, 1'b0);
      b = empty_board();
      b[42] = chess_eval_pkg::black_bishop;
      b[7] = chess_eval_pkg::black_rook;
      b[45] = chess_eval_pkg::white_pawn;
      run_board(b, 1'b0);
      b = empty_board();
      b[17] = chess_eval_pkg::white_pawn;
      b[46] = chess_eval_pkg::black_queen;
      b[21] = chess_eval_pkg::white_bishop;
      run_board(b, 1'b0);

      for (int t = 0; t < 20; t++)
      begin
         random_config();
         random_board(b);
         run_board(b, 1'b0);
      end

      random_board(b);
      run_board(b, 1'b1);

      $display("Verification passed");
      $finish;
   end

   initial
   begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog timeout: the tests did not finish within %0d cycles", watchdog_cycles);
      $display("Verification failed");
      $fatal(1, "simulation stopped by the watchdog");
   end

endmodule

/* chess_eval_top.f */
chess_eval_pkg.sv
eval_config_regs.sv
material_balance.sv
square_score_tree.sv
eval_sequencer.sv
chess_eval_top.sv
eval_clock_gen.sv
tb_chess_eval.sv

/* run_sim.sh */
#!/bin/sh
# build and run the chess evaluator testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_chess_eval \
   -f chess_eval_top.f \
   -o sim_chess_eval
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

./obj_dir/sim_chess_eval > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Verification passed$" "$log"; then
   echo "RESULT: PASS"
   exit 0
fi
echo "RESULT: FAIL"
exit 1
